// File: design/igr_epl_shim.sv
// --------------------
// ingress epl shim
// packs epl beats into frame aligned 64 byte segments per port
// --------------------

`default_nettype none

module igr_epl_shim
  import shim_epl_pkg::*;
  import shim_pb_pkg::*;
(
  input  logic                             cclk,
  input  logic                             rst,
  input  word_mask_t                       i_rx_v,
  input  epl_port_t                        i_rx_port,
  input  word_t [WORDS_PER_CYC-1:0]        i_rx_data,
  input  epl_md_u                          i_rx_md,
  input  epl_ts_t                          i_rx_ts,
  output logic [NUM_PORTS-1:0][1:0]        o_pb_v,
  output seg_data_t [NUM_PORTS-1:0][1:0]   o_pb_data,
  output seg_md_t [NUM_PORTS-1:0][1:0]     o_pb_md
);

  // staged beat, shared by all ports
  logic [NUM_PORTS-1:0]      port_e;
  word_t [WORDS_PER_CYC-1:0] words;
  word_mask_t                word_v;
  epl_md_u                   md;
  epl_ts_t                   ts;

  shim_rx_decode dec0 (
    .cclk      (cclk),
    .rst       (rst),
    .i_rx_v    (i_rx_v),
    .i_rx_port (i_rx_port),
    .i_rx_data (i_rx_data),
    .i_rx_md   (i_rx_md),
    .i_rx_ts   (i_rx_ts),
    .o_port_e  (port_e),
    .o_words   (words),
    .o_word_v  (word_v),
    .o_md      (md),
    .o_ts      (ts)
  );

  // one control and builder pair per logical port
  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
    shim_seg_if seg_if ();

    shim_seg_ctrl ctrl (
      .cclk     (cclk),
      .rst      (rst),
      .i_port_e (port_e[p]),
      .i_word_v (word_v),
      .i_md     (md),
      .i_ts     (ts),
      .seg      (seg_if.ctrl)
    );

    shim_seg_build build (
      .cclk      (cclk),
      .rst       (rst),
      .i_words   (words),
      .seg       (seg_if.build),
      .o_pb_v    (o_pb_v[p]),
      .o_pb_data (o_pb_data[p]),
      .o_pb_md   (o_pb_md[p])
    );
  end

endmodule

`default_nettype wire

// File: design/shim_epl_pkg.sv
// --------------------
// epl side types for the ingress shim
// words, valid mask, port number, metadata views and timestamp
// --------------------

`default_nettype none

package shim_epl_pkg;

  // words delivered per epl beat
  localparam int WORDS_PER_CYC = 8;

  typedef logic [63:0] word_t;
  typedef logic [WORDS_PER_CYC-1:0] word_mask_t;
  typedef logic [1:0] epl_port_t;
  typedef logic [31:0] epl_ts_t;
  typedef logic [2:0] epl_tc_t;

  // --------------------
  // metadata word
  // --------------------
  // sop and eop flags sit in bits 15 and 14 in both views

  typedef struct packed {
    logic        sop;
    logic        eop;
    logic [10:0] rsvd;
    epl_tc_t     tc;
  } epl_md_sop_t;

  typedef struct packed {
    logic        sop;
    logic        eop;
    logic [12:0] rsvd;
    logic        err;
  } epl_md_eop_t;

  // start beats are read through sop_v, end beats through eop_v
  typedef union packed {
    epl_md_sop_t sop_v;
    epl_md_eop_t eop_v;
  } epl_md_u;

endpackage

`default_nettype wire

// File: design/shim_pb_pkg.sv
// --------------------
// packet buffer side types for the ingress shim
// segment payload, segment metadata and fill count
// --------------------

`default_nettype none

package shim_pb_pkg;

  import shim_epl_pkg::*;

  localparam int NUM_PORTS = 4;
  localparam int SEG_WORDS = 8;

  // 64 byte segment, word 0 is the first word of the segment
  typedef word_t [SEG_WORDS-1:0] seg_data_t;

  // fill count of a partial segment, also used as word count
  typedef logic [3:0] fill_t;

  // count value of a complete segment
  localparam fill_t SEG_FULL = fill_t'(SEG_WORDS);

  // --------------------
  // segment metadata
  // --------------------
  typedef struct packed {
    logic    sop;
    logic    eop;
    // words in the segment, 1 to 8
    fill_t   cnt;
    // taken from the sop beat of the frame
    epl_tc_t tc;
    // only meaningful with eop
    logic    err;
    epl_ts_t ts;
  } seg_md_t;

endpackage

`default_nettype wire

// File: design/shim_rx_decode.sv
// --------------------
// epl input stage
// registers the beat and decodes the port to a one-hot enable
// --------------------

`default_nettype none

module shim_rx_decode
  import shim_epl_pkg::*;
  import shim_pb_pkg::*;
(
  input  logic                      cclk,
  input  logic                      rst,
  input  word_mask_t                i_rx_v,
  input  epl_port_t                 i_rx_port,
  input  word_t [WORDS_PER_CYC-1:0] i_rx_data,
  input  epl_md_u                   i_rx_md,
  input  epl_ts_t                   i_rx_ts,
  output logic [NUM_PORTS-1:0]      o_port_e,
  output word_t [WORDS_PER_CYC-1:0] o_words,
  output word_mask_t                o_word_v,
  output epl_md_u                   o_md,
  output epl_ts_t                   o_ts
);

  logic [NUM_PORTS-1:0] port_dec;

  // empty beats enable no port
  always_comb begin
    port_dec = '0;
    if (|i_rx_v) begin
      port_dec[i_rx_port] = 1'b1;
    end
  end

  // --------------------
  // staging flops
  // --------------------
  always_ff @(posedge cclk) begin
    if (rst) begin
      o_port_e <= '0;
      o_word_v <= '0;
    end else begin
      o_port_e <= port_dec;
      o_word_v <= i_rx_v;
    end
  end

  // invalid words are staged as zero so the builder pads with zeros
  always_ff @(posedge cclk) begin
    o_md <= i_rx_md;
    o_ts <= i_rx_ts;
    for (int i = 0; i < WORDS_PER_CYC; i++) begin
      o_words[i] <= i_rx_v[i] ? i_rx_data[i] : '0;
    end
  end

  // epl fills words from word 0 upward without gaps
  a_mask_contig : assert property (
    @(posedge cclk) disable iff (rst)
    (i_rx_v & (i_rx_v + 1'b1)) == '0
  ) else $error("epl word mask not contiguous from word 0");

endmodule

`default_nettype wire

// File: design/shim_seg_build.sv
// --------------------
// per port segment builder
// packs words behind the fill and registers leaving segments
// --------------------

`default_nettype none

module shim_seg_build
  import shim_epl_pkg::*;
  import shim_pb_pkg::*;
(
  input  logic                      cclk,
  input  logic                      rst,
  input  word_t [WORDS_PER_CYC-1:0] i_words,
  shim_seg_if.build                 seg,
  output logic [1:0]                o_pb_v,
  output seg_data_t [1:0]           o_pb_data,
  output seg_md_t [1:0]             o_pb_md
);

  logic                      p_wr;
  logic                      p_full;
  logic                      p_tail;
  fill_t                     p_fill;
  fill_t                     p_tcnt;
  seg_md_t                   p_md;
  word_t [WORDS_PER_CYC-1:0] p_words;

  seg_data_t                 acc_q;
  word_t [2*SEG_WORDS-1:0]   ext;
  seg_md_t                   md0;
  seg_md_t                   md1;

  // --------------------
  // control stage
  // --------------------
  always_ff @(posedge cclk) begin
    if (rst) begin
      p_wr   <= 1'b0;
      p_full <= 1'b0;
      p_tail <= 1'b0;
    end else begin
      p_wr   <= seg.seg_wr;
      p_full <= seg.emit_full;
      p_tail <= seg.emit_tail;
    end
  end

  always_ff @(posedge cclk) begin
    p_fill  <= seg.fill;
    p_tcnt  <= seg.tail_cnt;
    p_md    <= seg.seg_md;
    p_words <= i_words;
  end

  // kept words below the fill, new words above, overflow in the top half
  always_comb begin
    int f;
    f   = int'(p_fill);
    ext = '0;
    for (int j = 0; j < 2*SEG_WORDS; j++) begin
      if (j < f) begin
        ext[j] = acc_q[j];
      end else if (j - f < WORDS_PER_CYC) begin
        ext[j] = p_words[j - f];
      end
    end
  end

  // a spilled tail takes the eop, the full segment keeps the sop
  always_comb begin
    md0     = p_md;
    md0.eop = p_md.eop && !(p_full && p_tail);
    md0.err = p_md.err && !(p_full && p_tail);
    md1     = p_md;
    md1.sop = 1'b0;
    md1.cnt = p_tcnt;
  end

  // leftover words move down after a full segment leaves
  always_ff @(posedge cclk) begin
    if (p_wr) begin
      acc_q <= p_full ? ext[2*SEG_WORDS-1:SEG_WORDS] : ext[SEG_WORDS-1:0];
    end
  end

  // --------------------
  // output slots
  // --------------------
  always_ff @(posedge cclk) begin
    if (rst) begin
      o_pb_v <= '0;
    end else begin
      o_pb_v <= {p_full && p_tail, p_full || p_tail};
    end
  end

  always_ff @(posedge cclk) begin
    if (p_full || p_tail) begin
      o_pb_data[0] <= ext[SEG_WORDS-1:0];
      o_pb_data[1] <= ext[2*SEG_WORDS-1:SEG_WORDS];
      o_pb_md[0]   <= md0;
      o_pb_md[1]   <= md1;
    end
  end

endmodule

`default_nettype wire

// File: design/shim_seg_ctrl.sv
// --------------------
// per port segment control
// tracks fill and frame state, decides when segments leave
// --------------------

`default_nettype none

module shim_seg_ctrl
  import shim_epl_pkg::*;
  import shim_pb_pkg::*;
(
  input  logic       cclk,
  input  logic       rst,
  input  logic       i_port_e,
  input  word_mask_t i_word_v,
  input  epl_md_u    i_md,
  input  epl_ts_t    i_ts,
  shim_seg_if.ctrl   seg
);

  fill_t   fill_q;
  logic    in_frame_q;
  // no segment of the current frame has left yet
  logic    sop_pend_q;
  epl_tc_t tc_q;
  epl_ts_t ts_q;

  fill_t   n_words;
  fill_t   sum;
  fill_t   rem;
  logic    is_sop;
  logic    is_eop;
  logic    full;
  logic    tail;
  seg_md_t md;

  always_comb begin
    n_words = '0;
    for (int i = 0; i < WORDS_PER_CYC; i++) begin
      n_words = n_words + fill_t'(i_word_v[i]);
    end
  end

  // flags share their bit positions, either view works here
  assign is_sop = i_port_e && i_md.sop_v.sop;
  assign is_eop = i_port_e && i_md.eop_v.eop;

  // at most 7 + 8, fits in the fill width
  assign sum  = fill_q + n_words;
  assign full = i_port_e && (sum >= SEG_FULL);
  assign rem  = full ? sum - SEG_FULL : sum;
  assign tail = is_eop && (rem != '0);

  // --------------------
  // segment metadata
  // --------------------
  always_comb begin
    md     = '0;
    md.sop = is_sop || sop_pend_q;
    md.eop = is_eop;
    md.cnt = full ? SEG_FULL : rem;
    md.tc  = is_sop ? i_md.sop_v.tc : tc_q;
    md.err = is_eop && i_md.eop_v.err;
    md.ts  = is_sop ? i_ts : ts_q;
  end

  assign seg.seg_wr    = i_port_e;
  assign seg.fill      = fill_q;
  assign seg.emit_full = full;
  assign seg.emit_tail = tail;
  assign seg.tail_cnt  = rem;
  assign seg.seg_md    = md;

  // --------------------
  // state update
  // --------------------
  always_ff @(posedge cclk) begin
    if (rst) begin
      fill_q     <= '0;
      in_frame_q <= 1'b0;
      sop_pend_q <= 1'b0;
    end else if (i_port_e) begin
      fill_q     <= is_eop ? '0 : rem;
      in_frame_q <= (in_frame_q || is_sop) && !is_eop;
      sop_pend_q <= (sop_pend_q || is_sop) && !(full || tail);
    end
  end

  // frame attributes held for the later segments
  always_ff @(posedge cclk) begin
    if (is_sop) begin
      tc_q <= i_md.sop_v.tc;
      ts_q <= i_ts;
    end
  end

  a_sop_in_frame : assert property (
    @(posedge cclk) disable iff (rst)
    is_sop |-> !in_frame_q
  ) else $error("sop received while port already in frame");

  a_words_no_frame : assert property (
    @(posedge cclk) disable iff (rst)
    (i_port_e && !in_frame_q) |-> is_sop
  ) else $error("words received outside a frame without sop");

endmodule

`default_nettype wire

// File: design/shim_seg_if.sv
// --------------------
// per port segment control
// carries append and emit strobes from control to builder
// --------------------

`default_nettype none

interface shim_seg_if
  import shim_pb_pkg::*;
();

  // append this beat's words behind the current fill
  logic    seg_wr;
  // fill count before the append
  fill_t   fill;
  logic    emit_full;
  logic    emit_tail;
  // words in the tail segment
  fill_t   tail_cnt;
  // metadata of the first segment leaving this beat
  seg_md_t seg_md;

  modport ctrl (
    output seg_wr, fill, emit_full, emit_tail, tail_cnt, seg_md
  );

  modport build (
    input seg_wr, fill, emit_full, emit_tail, tail_cnt, seg_md
  );

endinterface

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the ingress shim testbench with verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
  --top-module tb_igr_epl_shim -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_igr_epl_shim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "test passed" "$LOG"; then
  exit 0
fi
echo "simulation did not report a pass"
exit 1

// File: test/tb_shim_model.svh
// --------------------
// segmentation reference model for the ingress shim
// per port word queues and expected segments with their due cycle
// --------------------

`ifndef TB_SHIM_MODEL_SVH
`define TB_SHIM_MODEL_SVH

typedef struct packed {
  int        cyc;
  logic      slot;
  seg_md_t   md;
  seg_data_t data;
} exp_seg_t;

// segments still to appear on each port, oldest first
exp_seg_t exp_q[NUM_PORTS][$];
// words of the open segment on each port
word_t    acc_q[NUM_PORTS][$];
// no segment of the current frame has been produced yet
logic     m_first[NUM_PORTS];
epl_tc_t  m_tc[NUM_PORTS];
epl_ts_t  m_ts[NUM_PORTS];

// a segment leaves once eight words have gathered, the remainder leaves at eop
task automatic model_beat(input int p, input int n, input word_t [WORDS_PER_CYC-1:0] w,
                          input epl_md_u md, input epl_ts_t ts, input int beat_cyc);
  exp_seg_t s;
  int       cnt;
  int       slot;
  slot = 0;
  if (n > 0 && md.sop_v.sop) begin
    m_first[p] = 1'b1;
    m_tc[p]    = md.sop_v.tc;
    m_ts[p]    = ts;
  end
  for (int i = 0; i < n; i++) begin
    acc_q[p].push_back(w[i]);
  end
  while (acc_q[p].size() >= SEG_WORDS ||
         (n > 0 && md.eop_v.eop && acc_q[p].size() > 0)) begin
    cnt = (acc_q[p].size() >= SEG_WORDS) ? SEG_WORDS : acc_q[p].size();
    s      = '0;
    s.cyc  = beat_cyc + SEG_LAT;
    s.slot = slot[0];
    // words past the count stay zero
    for (int j = 0; j < cnt; j++) begin
      s.data[j] = acc_q[p].pop_front();
    end
    s.md.sop = m_first[p];
    s.md.eop = (n > 0) && md.eop_v.eop && (acc_q[p].size() == 0);
    s.md.cnt = fill_t'(cnt);
    s.md.tc  = m_tc[p];
    s.md.err = s.md.eop && md.eop_v.err;
    s.md.ts  = m_ts[p];
    m_first[p] = 1'b0;
    exp_q[p].push_back(s);
    slot++;
  end
endtask

`endif

// File: test/tb_igr_epl_shim.sv
// --------------------
// testbench for the ingress epl shim
// random interleaved frames checked against a segmentation model
// --------------------

`default_nettype none

module tb_igr_epl_shim
  import shim_epl_pkg::*;
  import shim_pb_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  // cycles from input beat to segment output
  localparam int SEG_LAT     = 3;
  localparam int NUM_BEATS   = 4000;
  localparam int RUN_LIMIT   = 8000;
  localparam int DRAIN_LIMIT = 16;
  localparam int MAX_FRAME   = 40;

  logic                           cclk;
  logic                           rst;
  word_mask_t                     i_rx_v;
  epl_port_t                      i_rx_port;
  word_t [WORDS_PER_CYC-1:0]      i_rx_data;
  epl_md_u                        i_rx_md;
  epl_ts_t                        i_rx_ts;
  logic [NUM_PORTS-1:0][1:0]      o_pb_v;
  seg_data_t [NUM_PORTS-1:0][1:0] o_pb_data;
  seg_md_t [NUM_PORTS-1:0][1:0]   o_pb_md;

  integer seed;
  int     cyc;
  int     err_v;
  int     err_data;
  int     err_md;
  int     err_other;
  int     n_spill;
  // words left in the open frame of each port
  int     remain[NUM_PORTS];
  logic   started[NUM_PORTS];

  `include "tb_shim_model.svh"

  igr_epl_shim dut0 (
    .cclk      (cclk),
    .rst       (rst),
    .i_rx_v    (i_rx_v),
    .i_rx_port (i_rx_port),
    .i_rx_data (i_rx_data),
    .i_rx_md   (i_rx_md),
    .i_rx_ts   (i_rx_ts),
    .o_pb_v    (o_pb_v),
    .o_pb_data (o_pb_data),
    .o_pb_md   (o_pb_md)
  );

  always #4 cclk = ~cclk;

  // --------------------
  // compare tasks
  // --------------------
  task automatic check_seg_valid(input string name, input logic [1:0] got,
                                 input logic [1:0] exp);
    if (got !== exp) begin
      err_v++;
      $display("FAIL %0t %s got %b exp %b", $time, name, got, exp);
    end
  endtask

  task automatic check_seg_data(input string name, input seg_data_t got, input seg_data_t exp);
    if (got !== exp) begin
      err_data++;
      $display("FAIL %0t %s got %h exp %h", $time, name, got, exp);
    end
  endtask

  task automatic check_seg_md(input string name, input seg_md_t got, input seg_md_t exp);
    if (got !== exp) begin
      err_md++;
      $display("FAIL %0t %s got %h exp %h", $time, name, got, exp);
    end
  endtask

  // segments due this cycle must be on the outputs, nothing else may be
  task automatic sample_outputs();
    exp_seg_t   s;
    exp_seg_t   due[2];
    logic [1:0] ev;
    for (int p = 0; p < NUM_PORTS; p++) begin
      ev = '0;
      while (exp_q[p].size() > 0 && exp_q[p][0].cyc <= cyc) begin
        s           = exp_q[p].pop_front();
        due[s.slot] = s;
        ev[s.slot]  = 1'b1;
      end
      if (ev == 2'b11) begin
        n_spill++;
      end
      check_seg_valid($sformatf("o_pb_v[%0d]", p), o_pb_v[p], ev);
      for (int k = 0; k < 2; k++) begin
        if (ev[k] && o_pb_v[p][k]) begin
          check_seg_data($sformatf("o_pb_data[%0d][%0d]", p, k), o_pb_data[p][k], due[k].data);
          check_seg_md($sformatf("o_pb_md[%0d][%0d]", p, k), o_pb_md[p][k], due[k].md);
        end
      end
    end
  endtask

  // invalid words carry random data, the dut must not pass it on
  task automatic drive_beat(input int p, input int n, input epl_md_u md, input epl_ts_t ts);
    word_t [WORDS_PER_CYC-1:0] w;
    for (int i = 0; i < WORDS_PER_CYC; i++) begin
      w[i] = {$random(seed), $random(seed)};
    end
    @(posedge cclk);
    #1;
    cyc++;
    sample_outputs();
    i_rx_v    = word_mask_t'((9'd1 << n) - 9'd1);
    i_rx_port = epl_port_t'(p);
    i_rx_data = w;
    i_rx_md   = md;
    i_rx_ts   = ts;
    model_beat(p, n, w, md, ts, cyc);
  endtask

  function automatic logic frames_open();
    logic any;
    any = 1'b0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      any = any || (remain[p] > 0);
    end
    return any;
  endfunction

  function automatic logic segs_pending();
    logic any;
    any = 1'b0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      any = any || (exp_q[p].size() > 0);
    end
    return any;
  endfunction

  // --------------------
  // stimulus
  // --------------------
  initial begin
    epl_md_u md;
    int      p;
    int      n;
    int      beats;
    int      run;
    cclk      = 1'b0;
    rst       = 1'b1;
    i_rx_v    = '0;
    i_rx_port = '0;
    i_rx_data = '0;
    i_rx_md   = '0;
    i_rx_ts   = '0;
    seed      = 18;
    cyc       = 0;
    err_v     = 0;
    err_data  = 0;
    err_md    = 0;
    err_other = 0;
    n_spill   = 0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      remain[i]  = 0;
      started[i] = 1'b0;
      m_first[i] = 1'b0;
    end
    repeat (8) @(posedge cclk);
    #1;
    rst = 1'b0;

    // idle after reset, no segment may appear
    repeat (20) drive_beat(0, 0, '0, '0);

    beats = 0;
    run   = 0;
    while ((beats < NUM_BEATS || frames_open()) && run < RUN_LIMIT) begin
      p = $unsigned($random(seed)) % NUM_PORTS;
      if (remain[p] == 0 && beats < NUM_BEATS) begin
        remain[p] = 1 + $unsigned($random(seed)) % MAX_FRAME;
      end
      n = $unsigned($random(seed)) % (WORDS_PER_CYC + 1);
      if (n > remain[p]) begin
        n = remain[p];
      end
      md           = 16'($random(seed));
      md.sop_v.sop = (n > 0) && !started[p];
      md.eop_v.eop = (n > 0) && (n == remain[p]);
      drive_beat(p, n, md, epl_ts_t'($random(seed)));
      remain[p] -= n;
      if (n > 0) begin
        started[p] = (remain[p] > 0);
      end
      beats++;
      run++;
    end
    if (frames_open()) begin
      err_other++;
      $display("timeout: frames still open after %0d beats", run);
    end

    run = 0;
    while (segs_pending() && run < DRAIN_LIMIT) begin
      drive_beat(0, 0, '0, '0);
      run++;
    end
    if (segs_pending()) begin
      err_other++;
      $display("timeout: expected segments never appeared on the outputs");
    end
    repeat (4) drive_beat(0, 0, '0, '0);

    if (n_spill == 0) begin
      err_other++;
      $display("no beat produced a full segment and a tail together");
    end

    $display("errors: valid %0d data %0d metadata %0d other %0d",
             err_v, err_data, err_md, err_other);
    if (err_v + err_data + err_md + err_other == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+test
design/shim_epl_pkg.sv
design/shim_pb_pkg.sv
design/shim_seg_if.sv
design/shim_rx_decode.sv
design/shim_seg_ctrl.sv
design/shim_seg_build.sv
design/igr_epl_shim.sv
test/tb_igr_epl_shim.sv
